/* alu_core_cfg.svh */
`ifndef ALU_CORE_CFG_SVH
`define ALU_CORE_CFG_SVH

// data path width
`define XLEN 32

// entries in each stage input FIFO, also the credits a sender starts with
`define FIFO_DEPTH 2

// credits the result stage holds toward the retire consumer after reset
`define RETIRE_CREDITS 4

`endif

/* isa_pkg.sv */
package isa_pkg;

`include "alu_core_cfg.svh"

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [4:0]       reg_addr_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [4:0] {
        ALU_ADD   = 5'd0,
        ALU_SUB   = 5'd1,
        ALU_EQU   = 5'd2,
        ALU_NEQ   = 5'd3,
        ALU_SLT   = 5'd4,
        ALU_SGE   = 5'd5,
        ALU_SLTU  = 5'd6,
        ALU_SGEU  = 5'd7,
        ALU_XOR   = 5'd8,
        ALU_OR    = 5'd9,
        ALU_SLL   = 5'd10,
        ALU_SRL   = 5'd11,
        ALU_SRA   = 5'd12,
        ALU_AND   = 5'd13,
        ALU_NO_OP = 5'd31
    } alu_ctrl_t;

    localparam logic [2:0] F3_ADD  = 3'b000; // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000; // funct3 of BRANCH
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT  = 7'b0100000; // selects SUB and SRA

endpackage

/* pipe_pkg.sv */
package pipe_pkg;

    typedef struct packed {
        isa_pkg::xlen_t instr;
        isa_pkg::xlen_t pc;
    } fetch_t;

    typedef struct packed {
        isa_pkg::xlen_t     op_a;
        isa_pkg::xlen_t     op_b;
        isa_pkg::alu_ctrl_t alu_ctrl;
        isa_pkg::reg_addr_t rd;
        logic               we;
        logic               is_branch;
        isa_pkg::xlen_t     br_target;
        isa_pkg::xlen_t     pc_plus4;
    } ex_op_t;

    typedef struct packed {
        isa_pkg::xlen_t     data;
        isa_pkg::reg_addr_t rd;
        logic               we;
        logic               taken;
        isa_pkg::xlen_t     next_pc;
    } ex_res_t;

endpackage

/* credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output logic     empty_o,
    output payload_t data_o,
    output logic     credit_o
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    assign empty_o = (count == '0);
    assign data_o  = mem[rd_ptr];
    assign do_pop  = pop_i && !empty_o; // the sender's credits keep push from overflowing

    always_ff @(posedge clk) begin
        if (push_i) mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= do_pop; // one credit back for each freed slot
            if (push_i) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push_i && !do_pop) count <= count + 1'b1;
            else if (!push_i && do_pop) count <= count - 1'b1;
        end
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               arst_n_i,
    input  isa_pkg::reg_addr_t raddr1_i,
    input  isa_pkg::reg_addr_t raddr2_i,
    output isa_pkg::xlen_t     rdata1_o,
    output isa_pkg::xlen_t     rdata2_o,
    input  logic               we_i,
    input  isa_pkg::reg_addr_t waddr_i,
    input  isa_pkg::xlen_t     wdata_i
);
    import isa_pkg::*;

    xlen_t regs [32];

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (we_i && waddr_i != '0) begin // x0 never leaves its reset value
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "alu_core_cfg.svh"

module decode_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               instr_valid_i,
    input  isa_pkg::xlen_t     instr_i,
    input  isa_pkg::xlen_t     pc_i,
    output logic               instr_credit_o,
    output isa_pkg::reg_addr_t raddr1_o,
    output isa_pkg::reg_addr_t raddr2_o,
    input  isa_pkg::xlen_t     rdata1_i,
    input  isa_pkg::xlen_t     rdata2_i,
    input  logic               wb_we_i,
    input  isa_pkg::reg_addr_t wb_addr_i,
    output logic               dx_valid_o,
    output isa_pkg::xlen_t     dx_op_a_o,
    output isa_pkg::xlen_t     dx_op_b_o,
    output isa_pkg::alu_ctrl_t dx_alu_ctrl_o,
    output isa_pkg::reg_addr_t dx_rd_o,
    output logic               dx_we_o,
    output logic               dx_is_branch_o,
    output isa_pkg::xlen_t     dx_br_target_o,
    output isa_pkg::xlen_t     dx_pc_plus4_o,
    input  logic               dx_credit_i
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CW = $clog2(`FIFO_DEPTH + 1);

    fetch_t        in_entry;
    fetch_t        head;
    logic          fifo_empty;
    logic          issue;
    logic [CW-1:0] credits;
    logic [31:0]   pending;
    logic [31:0]   pending_nxt;
    opcode_t       opcode;
    logic [2:0]    funct3;
    logic          alt;
    reg_addr_t     rs1;
    reg_addr_t     rs2;
    reg_addr_t     rd;
    logic          is_op;
    logic          is_imm;
    logic          is_branch;
    logic          writes_rd;
    xlen_t         imm_i;
    xlen_t         imm_b;
    alu_ctrl_t     alu_ctrl;

    assign in_entry = '{instr: instr_i, pc: pc_i};

    credit_fifo #(
        .payload_t (fetch_t),
        .DEPTH     (`FIFO_DEPTH)
    ) i_fifo (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .push_i   (instr_valid_i),
        .data_i   (in_entry),
        .pop_i    (issue),
        .empty_o  (fifo_empty),
        .data_o   (head),
        .credit_o (instr_credit_o)
    );

    assign opcode    = opcode_t'(head.instr[6:0]);
    assign funct3    = head.instr[14:12];
    assign alt       = (head.instr[31:25] == F7_ALT);
    assign rd        = head.instr[11:7];
    assign rs1       = head.instr[19:15];
    assign rs2       = head.instr[24:20];
    assign is_op     = (opcode == OPC_OP);
    assign is_imm    = (opcode == OPC_OP_IMM);
    assign is_branch = (opcode == OPC_BRANCH);
    assign writes_rd = is_op || is_imm; // branches and unknown opcodes never write
    assign imm_i     = {{(`XLEN - 12){head.instr[31]}}, head.instr[31:20]};
    assign imm_b     = {{(`XLEN - 12){head.instr[31]}}, head.instr[7],
                        head.instr[30:25], head.instr[11:8], 1'b0};
    assign raddr1_o  = rs1;
    assign raddr2_o  = rs2;

    always_comb begin
        alu_ctrl = ALU_NO_OP;
        if (is_op || is_imm) begin
            case (funct3)
                F3_ADD:  alu_ctrl = (is_op && alt) ? ALU_SUB : ALU_ADD;
                F3_SLL:  alu_ctrl = ALU_SLL;
                F3_SLT:  alu_ctrl = ALU_SLT;
                F3_SLTU: alu_ctrl = ALU_SLTU;
                F3_XOR:  alu_ctrl = ALU_XOR;
                F3_SR:   alu_ctrl = alt ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_ctrl = ALU_OR;
                default: alu_ctrl = ALU_AND;
            endcase
        end else if (is_branch) begin
            case (funct3)
                F3_BEQ:  alu_ctrl = ALU_EQU;
                F3_BNE:  alu_ctrl = ALU_NEQ;
                F3_BLT:  alu_ctrl = ALU_SLT;
                F3_BGE:  alu_ctrl = ALU_SGE;
                F3_BLTU: alu_ctrl = ALU_SLTU;
                F3_BGEU: alu_ctrl = ALU_SGEU;
                default: alu_ctrl = ALU_NO_OP;
            endcase
        end
    end

    // hold the head while any register it names is still owed a write
    // only OP and BRANCH carry an rs2, in OP-IMM those bits are immediate
    assign issue = !fifo_empty && (credits != '0)
                   && !(pending[rs1] || ((is_op || is_branch) && pending[rs2])
                        || pending[rd]);

    always_comb begin
        pending_nxt = pending;
        if (wb_we_i) pending_nxt[wb_addr_i] = 1'b0;
        if (issue && writes_rd && rd != '0) pending_nxt[rd] = 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credits    <= CW'(`FIFO_DEPTH);
            pending    <= '0;
            dx_valid_o <= 1'b0;
        end else begin
            dx_valid_o <= issue;
            pending    <= pending_nxt;
            if (issue && !dx_credit_i) credits <= credits - 1'b1;
            else if (!issue && dx_credit_i) credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            dx_op_a_o      <= rdata1_i;
            dx_op_b_o      <= is_imm ? imm_i : rdata2_i;
            dx_alu_ctrl_o  <= alu_ctrl;
            dx_rd_o        <= rd;
            dx_we_o        <= writes_rd;
            dx_is_branch_o <= is_branch;
            dx_br_target_o <= head.pc + imm_b;
            dx_pc_plus4_o  <= head.pc + xlen_t'(4);
        end
    end

endmodule

/* ex_stage.sv */
`timescale 1ns/1ps
`include "alu_core_cfg.svh"

module ex_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               dx_valid_i,
    input  isa_pkg::xlen_t     dx_op_a_i,
    input  isa_pkg::xlen_t     dx_op_b_i,
    input  isa_pkg::alu_ctrl_t dx_alu_ctrl_i,
    input  isa_pkg::reg_addr_t dx_rd_i,
    input  logic               dx_we_i,
    input  logic               dx_is_branch_i,
    input  isa_pkg::xlen_t     dx_br_target_i,
    input  isa_pkg::xlen_t     dx_pc_plus4_i,
    output logic               dx_credit_o,
    output logic               xr_valid_o,
    output isa_pkg::xlen_t     xr_data_o,
    output isa_pkg::reg_addr_t xr_rd_o,
    output logic               xr_we_o,
    output logic               xr_taken_o,
    output isa_pkg::xlen_t     xr_next_pc_o,
    input  logic               xr_credit_i
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CW = $clog2(`FIFO_DEPTH + 1);

    ex_op_t        in_entry;
    ex_op_t        op;
    logic          fifo_empty;
    logic          pop;
    logic [CW-1:0] credits;
    xlen_t         op_c;
    logic          taken;

    assign in_entry = '{op_a: dx_op_a_i, op_b: dx_op_b_i, alu_ctrl: dx_alu_ctrl_i,
                        rd: dx_rd_i, we: dx_we_i, is_branch: dx_is_branch_i,
                        br_target: dx_br_target_i, pc_plus4: dx_pc_plus4_i};

    credit_fifo #(
        .payload_t (ex_op_t),
        .DEPTH     (`FIFO_DEPTH)
    ) i_fifo (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .push_i   (dx_valid_i),
        .data_i   (in_entry),
        .pop_i    (pop),
        .empty_o  (fifo_empty),
        .data_o   (op),
        .credit_o (dx_credit_o)
    );

    always_comb begin
        case (op.alu_ctrl)
            ALU_ADD:  op_c = op.op_a + op.op_b;
            ALU_SUB:  op_c = op.op_a - op.op_b;
            ALU_EQU:  op_c = xlen_t'(op.op_a == op.op_b);
            ALU_NEQ:  op_c = xlen_t'(op.op_a != op.op_b);
            ALU_SLT:  op_c = xlen_t'($signed(op.op_a) < $signed(op.op_b));
            ALU_SGE:  op_c = xlen_t'($signed(op.op_a) >= $signed(op.op_b));
            ALU_SLTU: op_c = xlen_t'(op.op_a < op.op_b);
            ALU_SGEU: op_c = xlen_t'(op.op_a >= op.op_b);
            ALU_XOR:  op_c = op.op_a ^ op.op_b;
            ALU_OR:   op_c = op.op_a | op.op_b;
            ALU_SLL:  op_c = op.op_a << op.op_b[4:0];
            ALU_SRL:  op_c = op.op_a >> op.op_b[4:0];
            ALU_SRA:  op_c = $signed(op.op_a) >>> op.op_b[4:0];
            ALU_AND:  op_c = op.op_a & op.op_b;
            default:  op_c = '0; // NO_OP and unknown opcodes retire with zero
        endcase
    end

    assign taken = op.is_branch && (op_c != '0); // compare result is 0 or 1
    assign pop   = !fifo_empty && (credits != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credits    <= CW'(`FIFO_DEPTH);
            xr_valid_o <= 1'b0;
        end else begin
            xr_valid_o <= pop;
            if (pop && !xr_credit_i) credits <= credits - 1'b1;
            else if (!pop && xr_credit_i) credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            xr_data_o    <= op_c;
            xr_rd_o      <= op.rd;
            xr_we_o      <= op.we;
            xr_taken_o   <= taken;
            xr_next_pc_o <= taken ? op.br_target : op.pc_plus4;
        end
    end

endmodule

/* result_stage.sv */
`timescale 1ns/1ps
`include "alu_core_cfg.svh"

module result_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               xr_valid_i,
    input  isa_pkg::xlen_t     xr_data_i,
    input  isa_pkg::reg_addr_t xr_rd_i,
    input  logic               xr_we_i,
    input  logic               xr_taken_i,
    input  isa_pkg::xlen_t     xr_next_pc_i,
    output logic               xr_credit_o,
    output logic               wb_we_o,
    output isa_pkg::reg_addr_t wb_addr_o,
    output isa_pkg::xlen_t     wb_data_o,
    output logic               retire_valid_o,
    output isa_pkg::reg_addr_t retire_rd_o,
    output logic               retire_we_o,
    output isa_pkg::xlen_t     retire_data_o,
    output logic               retire_taken_o,
    output isa_pkg::xlen_t     retire_next_pc_o,
    input  logic               retire_credit_i
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CW = $clog2(`RETIRE_CREDITS + 1);

    ex_res_t       in_entry;
    ex_res_t       head;
    logic          fifo_empty;
    logic          pop;
    logic [CW-1:0] credits;
    reg_addr_t     rd_q;
    xlen_t         data_q;
    logic          we_q;

    assign in_entry = '{data: xr_data_i, rd: xr_rd_i, we: xr_we_i,
                        taken: xr_taken_i, next_pc: xr_next_pc_i};

    credit_fifo #(
        .payload_t (ex_res_t),
        .DEPTH     (`FIFO_DEPTH)
    ) i_fifo (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .push_i   (xr_valid_i),
        .data_i   (in_entry),
        .pop_i    (pop),
        .empty_o  (fifo_empty),
        .data_o   (head),
        .credit_o (xr_credit_o)
    );

    assign pop = !fifo_empty && (credits != '0);

    // write-back and retire leave in the same cycle from the same registers
    assign wb_we_o       = retire_valid_o && we_q;
    assign wb_addr_o     = rd_q;
    assign wb_data_o     = data_q;
    assign retire_rd_o   = rd_q;
    assign retire_we_o   = we_q;
    assign retire_data_o = data_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credits        <= CW'(`RETIRE_CREDITS);
            retire_valid_o <= 1'b0;
            we_q           <= 1'b0;
        end else begin
            retire_valid_o <= pop;
            if (pop) we_q <= head.we;
            if (pop && !retire_credit_i) credits <= credits - 1'b1;
            else if (!pop && retire_credit_i) credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rd_q             <= head.rd;
            data_q           <= head.data;
            retire_taken_o   <= head.taken;
            retire_next_pc_o <= head.next_pc;
        end
    end

endmodule

/* alu_core.sv */
`timescale 1ns/1ps

module alu_core (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               instr_valid_i,
    input  isa_pkg::xlen_t     instr_i,
    input  isa_pkg::xlen_t     pc_i,
    output logic               instr_credit_o,
    output logic               retire_valid_o,
    output isa_pkg::reg_addr_t retire_rd_o,
    output logic               retire_we_o,
    output isa_pkg::xlen_t     retire_data_o,
    output logic               retire_taken_o,
    output isa_pkg::xlen_t     retire_next_pc_o,
    input  logic               retire_credit_i
);
    import isa_pkg::*;

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    xlen_t     rdata1;
    xlen_t     rdata2;
    logic      wb_we;
    reg_addr_t wb_addr;
    xlen_t     wb_data;
    logic      dx_valid;
    xlen_t     dx_op_a;
    xlen_t     dx_op_b;
    alu_ctrl_t dx_alu_ctrl;
    reg_addr_t dx_rd;
    logic      dx_we;
    logic      dx_is_branch;
    xlen_t     dx_br_target;
    xlen_t     dx_pc_plus4;
    logic      dx_credit;
    logic      xr_valid;
    xlen_t     xr_data;
    reg_addr_t xr_rd;
    logic      xr_we;
    logic      xr_taken;
    xlen_t     xr_next_pc;
    logic      xr_credit;

    decode_stage i_decode_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .instr_credit_o (instr_credit_o),
        .raddr1_o       (raddr1),
        .raddr2_o       (raddr2),
        .rdata1_i       (rdata1),
        .rdata2_i       (rdata2),
        .wb_we_i        (wb_we),
        .wb_addr_i      (wb_addr),
        .dx_valid_o     (dx_valid),
        .dx_op_a_o      (dx_op_a),
        .dx_op_b_o      (dx_op_b),
        .dx_alu_ctrl_o  (dx_alu_ctrl),
        .dx_rd_o        (dx_rd),
        .dx_we_o        (dx_we),
        .dx_is_branch_o (dx_is_branch),
        .dx_br_target_o (dx_br_target),
        .dx_pc_plus4_o  (dx_pc_plus4),
        .dx_credit_i    (dx_credit)
    );

    ex_stage i_ex_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .dx_valid_i     (dx_valid),
        .dx_op_a_i      (dx_op_a),
        .dx_op_b_i      (dx_op_b),
        .dx_alu_ctrl_i  (dx_alu_ctrl),
        .dx_rd_i        (dx_rd),
        .dx_we_i        (dx_we),
        .dx_is_branch_i (dx_is_branch),
        .dx_br_target_i (dx_br_target),
        .dx_pc_plus4_i  (dx_pc_plus4),
        .dx_credit_o    (dx_credit),
        .xr_valid_o     (xr_valid),
        .xr_data_o      (xr_data),
        .xr_rd_o        (xr_rd),
        .xr_we_o        (xr_we),
        .xr_taken_o     (xr_taken),
        .xr_next_pc_o   (xr_next_pc),
        .xr_credit_i    (xr_credit)
    );

    result_stage i_result_stage (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .xr_valid_i       (xr_valid),
        .xr_data_i        (xr_data),
        .xr_rd_i          (xr_rd),
        .xr_we_i          (xr_we),
        .xr_taken_i       (xr_taken),
        .xr_next_pc_i     (xr_next_pc),
        .xr_credit_o      (xr_credit),
        .wb_we_o          (wb_we),
        .wb_addr_o        (wb_addr),
        .wb_data_o        (wb_data),
        .retire_valid_o   (retire_valid_o),
        .retire_rd_o      (retire_rd_o),
        .retire_we_o      (retire_we_o),
        .retire_data_o    (retire_data_o),
        .retire_taken_o   (retire_taken_o),
        .retire_next_pc_o (retire_next_pc_o),
        .retire_credit_i  (retire_credit_i)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (wb_we),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data)
    );

endmodule

/* tb_alu_core.sv */
`timescale 1ns/1ps
`include "alu_core_cfg.svh"

module tb_alu_core;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam logic [6:0] OPC_LOAD = 7'b0000011; // loads are outside this core

    logic      clk;
    logic      arst_n_i;
    logic      instr_valid_i;
    xlen_t     instr_i;
    xlen_t     pc_i;
    logic      instr_credit_o;
    logic      retire_valid_o;
    reg_addr_t retire_rd_o;
    logic      retire_we_o;
    xlen_t     retire_data_o;
    logic      retire_taken_o;
    xlen_t     retire_next_pc_o;
    logic      retire_credit_i = 1'b0;

    xlen_t     mregs [32];
    ex_res_t   exp_q [$];
    xlen_t     fetch_pc;
    integer    seed = 67685;
    int        errors = 0;
    int        sent_cnt = 0;
    int        credits_back = 0;
    int        retired_cnt = 0;
    int        credits_given = 0;
    int        cycles = 0;
    logic      hold_retire = 1'b0;

    alu_core i_alu_core (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .pc_i             (pc_i),
        .instr_credit_o   (instr_credit_o),
        .retire_valid_o   (retire_valid_o),
        .retire_rd_o      (retire_rd_o),
        .retire_we_o      (retire_we_o),
        .retire_data_o    (retire_data_o),
        .retire_taken_o   (retire_taken_o),
        .retire_next_pc_o (retire_next_pc_o),
        .retire_credit_i  (retire_credit_i)
    );

    always #50 clk = ~clk;

    task automatic compare_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_reg_addr(input string name, input reg_addr_t got,
                                    input reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    function automatic xlen_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic xlen_t enc_i(logic [6:0] opc, logic [11:0] imm, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // architectural effect of one instruction on the model registers
    function automatic ex_res_t exec_model(xlen_t instr, xlen_t pc);
        ex_res_t    r;
        xlen_t      a;
        xlen_t      b;
        logic [2:0] f3;
        logic       alt;
        a   = mregs[instr[19:15]];
        f3  = instr[14:12];
        alt = (instr[31:25] == 7'b0100000);
        r   = '0;
        r.rd      = instr[11:7];
        r.next_pc = pc + 32'd4;
        if (instr[6:0] == OPC_OP || instr[6:0] == OPC_OP_IMM) begin
            if (instr[6:0] == OPC_OP) b = mregs[instr[24:20]];
            else b = {{20{instr[31]}}, instr[31:20]};
            r.we = 1'b1;
            case (f3)
                3'b000: r.data = (instr[6:0] == OPC_OP && alt) ? a - b : a + b;
                3'b001: r.data = a << b[4:0];
                3'b010: r.data = {31'd0, $signed(a) < $signed(b)};
                3'b011: r.data = {31'd0, a < b};
                3'b100: r.data = a ^ b;
                3'b101: begin
                    if (alt) r.data = $signed(a) >>> b[4:0];
                    else r.data = a >> b[4:0];
                end
                3'b110: r.data = a | b;
                default: r.data = a & b;
            endcase
            if (r.rd != 5'd0) mregs[r.rd] = r.data; // x0 stays zero
        end else if (instr[6:0] == OPC_BRANCH) begin
            b = mregs[instr[24:20]];
            case (f3)
                3'b000: r.taken = (a == b);
                3'b001: r.taken = (a != b);
                3'b100: r.taken = ($signed(a) < $signed(b));
                3'b101: r.taken = ($signed(a) >= $signed(b));
                3'b110: r.taken = (a < b);
                3'b111: r.taken = (a >= b);
                default: r.taken = 1'b0;
            endcase
            r.data = {31'd0, r.taken};
            if (r.taken) begin
                r.next_pc = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
            end
        end
        return r;
    endfunction

    // waits for an instruction credit, then drives one valid pulse
    task automatic send_instr(input xlen_t instr);
        while (`FIFO_DEPTH + credits_back - sent_cnt <= 0) @(negedge clk);
        exp_q.push_back(exec_model(instr, fetch_pc));
        instr_valid_i = 1'b1;
        instr_i       = instr;
        pc_i          = fetch_pc;
        sent_cnt++;
        fetch_pc = fetch_pc + 32'd4;
        @(negedge clk);
        instr_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk); // lets the last retire credit go back
    endtask

    always @(posedge clk) begin : retire_monitor
        ex_res_t e;
        cycles++;
        if (instr_credit_o) credits_back++;
        if (retire_valid_o) begin
            retired_cnt++;
            if (exp_q.size() == 0) begin
                $display("retire of rd x%0d arrived with no instruction expected", retire_rd_o);
                errors++;
            end else begin
                e = exp_q.pop_front();
                compare_reg_addr("retire_rd_o", retire_rd_o, e.rd);
                compare_flag("retire_we_o", retire_we_o, e.we);
                compare_word("retire_data_o", retire_data_o, e.data);
                compare_flag("retire_taken_o", retire_taken_o, e.taken);
                compare_word("retire_next_pc_o", retire_next_pc_o, e.next_pc);
            end
        end
        if (cycles > 20 * sent_cnt + 1000) begin
            $display("timeout after %0d cycles, %0d retires still outstanding",
                     cycles, exp_q.size());
            $display("errors: %0d, sent: %0d, retired: %0d", errors, sent_cnt, retired_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // hands back one retire credit per retire unless a test holds them
    always @(negedge clk) begin
        if (!hold_retire && credits_given < retired_cnt) begin
            retire_credit_i = 1'b1;
            credits_given++;
        end else begin
            retire_credit_i = 1'b0;
        end
    end

    task automatic check_reset_idle();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            compare_flag("retire_valid_o", retire_valid_o, 1'b0);
            compare_flag("instr_credit_o", instr_credit_o, 1'b0);
        end
        arst_n_i = 1'b1;
        repeat (5) begin
            @(negedge clk);
            compare_flag("retire_valid_o", retire_valid_o, 1'b0);
            compare_flag("instr_credit_o", instr_credit_o, 1'b0);
        end
        send_instr(enc_i(OPC_OP_IMM, 12'd0, 5'd0, 3'b000, 5'd1));
        wait_drain();
    endtask

    task automatic exercise_alu_ops();
        logic [11:0] imm;
        reg_addr_t   src1;
        reg_addr_t   src2;
        for (int r = 1; r <= 4; r++) begin
            imm = 12'($random(seed));
            if (r == 3) imm[11] = 1'b1; // negative operand for the signed compares
            if (r == 4) imm[11] = 1'b0;
            send_instr(enc_i(OPC_OP_IMM, imm, 5'd0, 3'b000, reg_addr_t'(r)));
        end
        for (int p = 0; p < 3; p++) begin
            src1 = (p == 0) ? 5'd3 : (p == 1) ? 5'd4 : 5'd1;
            src2 = (p == 0) ? 5'd4 : (p == 1) ? 5'd3 : 5'd2;
            for (int f = 0; f < 8; f++) begin
                send_instr(enc_r(7'h00, src2, src1, 3'(f), reg_addr_t'(10 + f)));
                imm = 12'($random(seed));
                if (f == 1 || f == 5) imm[11:5] = 7'h00; // shift immediates carry a shamt only
                send_instr(enc_i(OPC_OP_IMM, imm, src1, 3'(f), reg_addr_t'(18 + f)));
                if (f == 0 || f == 5) send_instr(enc_r(7'h20, src2, src1, 3'(f), 5'd26));
                if (f == 5) send_instr(enc_i(OPC_OP_IMM, {7'h20, imm[4:0]}, src1, 3'(f), 5'd27));
            end
        end
        wait_drain();
    endtask

    task automatic chain_dependences();
        logic [11:0] imm;
        send_instr(enc_i(OPC_OP_IMM, 12'h35a, 5'd0, 3'b000, 5'd5));
        for (int i = 0; i < 6; i++) begin
            imm = 12'($random(seed));
            send_instr(enc_i(OPC_OP_IMM, imm, 5'd5, 3'b000, 5'd5)); // rd is its own source
            send_instr(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
            send_instr(enc_r(7'h20, 5'd5, 5'd6, 3'b000, 5'd7));
            send_instr(enc_r(7'h00, 5'd7, 5'd6, 3'b100, 5'd5));
        end
        wait_drain();
    endtask

    task automatic cover_branches();
        logic [12:0] off;
        logic [2:0]  f3;
        reg_addr_t   src1;
        reg_addr_t   src2;
        send_instr(enc_i(OPC_OP_IMM, 12'hffb, 5'd0, 3'b000, 5'd1));
        send_instr(enc_i(OPC_OP_IMM, 12'h007, 5'd0, 3'b000, 5'd2));
        send_instr(enc_i(OPC_OP_IMM, 12'h007, 5'd0, 3'b000, 5'd3));
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            for (int p = 0; p < 3; p++) begin
                // equal pair, then negative against positive both ways round
                src1 = (p == 1) ? 5'd1 : 5'd2;
                src2 = (p == 0) ? 5'd3 : (p == 1) ? 5'd2 : 5'd1;
                off = 13'($random(seed));
                off[0] = 1'b0;
                send_instr(enc_b(off, src2, src1, f3));
            end
        end
        wait_drain();
    endtask

    task automatic try_special_cases();
        send_instr(enc_i(OPC_OP_IMM, 12'h123, 5'd0, 3'b000, 5'd0));
        send_instr(enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd8)); // x0 must still read zero
        send_instr(enc_i(OPC_OP_IMM, 12'h005, 5'd0, 3'b000, 5'd9));
        send_instr(enc_i(OPC_LOAD, 12'h040, 5'd9, 3'b010, 5'd9));
        send_instr(enc_r(7'h00, 5'd0, 5'd9, 3'b000, 5'd10));
        wait_drain();
    endtask

    task automatic withhold_retire_credits();
        int start;
        hold_retire = 1'b1;
        start = retired_cnt;
        for (int i = 0; i < 10; i++) begin
            send_instr(enc_i(OPC_OP_IMM, 12'($random(seed)), reg_addr_t'(1 + i % 4),
                             3'b000, reg_addr_t'(11 + i)));
        end
        repeat (30) @(negedge clk);
        if (retired_cnt - start > `RETIRE_CREDITS) begin
            $display("%0d retires seen while credits were withheld, only %0d allowed",
                     retired_cnt - start, `RETIRE_CREDITS);
            errors++;
        end
        hold_retire = 1'b0;
        wait_drain();
        if (credits_back != sent_cnt) begin
            $display("MISMATCH instr_credit_o count: got 0x%0h expected 0x%0h",
                     credits_back, sent_cnt);
            errors++;
        end
    endtask

    initial begin
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        fetch_pc      = 32'h0000_0100;
        for (int i = 0; i < 32; i++) mregs[i] = '0;
        check_reset_idle();
        exercise_alu_ops();
        chain_dependences();
        cover_branches();
        try_special_cases();
        withhold_retire_credits();
        $display("errors: %0d, sent: %0d, retired: %0d", errors, sent_cnt, retired_cnt);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
credit_fifo.sv
reg_file.sv
decode_stage.sv
ex_stage.sv
result_stage.sv
alu_core.sv
tb_alu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_alu_core -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
